// File: verilog.f
+incdir+sim
hw/cpuCtrlPkg.sv
hw/instrDecoder.sv
hw/mainFsm.sv
hw/multicycleController.sv
sim/clockGen.sv
sim/controllerTb.sv

// File: Makefile
TOP = controllerTb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/1ps -f verilog.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/ctrlModel.svh
// Reference model of the multicycle controller
// Needs cpuCtrlPkg imported by the including module

`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

// Everything the DUT shows in one cycle
typedef struct packed {
    fsmCtrl_t ctrl;
    aluCtrl_e aluControl;
    immSrc_e  immSrc;
} expected_t;

// Successor state, reset handled by the caller
function automatic ctrlState_e refNextState(input ctrlState_e state, input instrFields_t fields);
    ctrlState_e next;
    next = Error;
    case (state)
        Fetch:
        begin
            next = Decode;
        end
        Decode:
        begin
            if (fields.op == opLoad || fields.op == opStore)
                next = MemAddr;
            else if (fields.op == opRType)
                next = ExecuteR;
            else if (fields.op == opIType)
                next = ExecuteI;
            else if (fields.op == opJal)
                next = Jal;
            else if (fields.op == opBranch)
                next = Beq;
            else if (fields.op == opLui)
                next = Lui;
            else if (fields.op == opNop)
                next = Fetch;
        end
        MemAddr:
        begin
            if (fields.op == opLoad)
                next = MemRead;
            else if (fields.op == opStore)
                next = MemWrite;
        end
        MemRead:
        begin
            next = MemWB;
        end
        ExecuteR, ExecuteI, Jal, Lui:
        begin
            next = AluWB;
        end
        MemWB, MemWrite, AluWB, Beq:
        begin
            next = Fetch;
        end
        // Error and anything else stays in Error
        default:
        begin
            next = Error;
        end
    endcase
    return next;
endfunction

// ALU operation from the class and funct fields
function automatic aluCtrl_e refAluControl(input aluOp_e cls, input instrFields_t fields);
    if (cls == AluSub)
        return CtrlSub;
    if (cls != AluFunct)
        return CtrlAdd;
    case (fields.funct3)
        // Sub only for the register form with bit 30 set
        3'b000: return (fields.op[5] && fields.funct7b5) ? CtrlSub : CtrlAdd;
        3'b010: return CtrlSlt;
        3'b100: return CtrlXor;
        3'b110: return CtrlOr;
        3'b111: return CtrlAnd;
        default: return CtrlAdd;
    endcase
endfunction

function automatic immSrc_e refImmSrc(input logic [6:0] op);
    if (op == opStore)
        return ImmS;
    if (op == opBranch)
        return ImmB;
    if (op == opJal)
        return ImmJ;
    if (op == opLui)
        return ImmU;
    // Loads, I-type and unknown
    return ImmI;
endfunction

// Expected outputs of one state
function automatic expected_t refOutputs(input ctrlState_e state, input instrFields_t fields,
                                         input logic zeroIn);
    expected_t want;
    aluOp_e    cls;
    want = '0;
    cls  = AluAdd;
    case (state)
        Fetch:
        begin
            want.ctrl.irWrite   = 1'b1;
            want.ctrl.pcWrite   = 1'b1;
            want.ctrl.adrSrc    = AdrFromPc;
            want.ctrl.aluSrcA   = SrcAPc;
            want.ctrl.aluSrcB   = SrcBFour;
            want.ctrl.resultSrc = ResAluResult;
        end
        Decode:
        begin
            want.ctrl.aluSrcA = SrcAOldPc;
            want.ctrl.aluSrcB = SrcBImm;
        end
        MemAddr, ExecuteI:
        begin
            want.ctrl.aluSrcA = SrcAReg;
            want.ctrl.aluSrcB = SrcBImm;
            if (state == ExecuteI)
                cls = AluFunct;
        end
        MemRead, MemWrite:
        begin
            want.ctrl.adrSrc    = AdrFromResult;
            want.ctrl.resultSrc = ResAluOut;
            want.ctrl.memWrite  = (state == MemWrite);
        end
        MemWB:
        begin
            want.ctrl.resultSrc = ResData;
            want.ctrl.regWrite  = 1'b1;
        end
        ExecuteR:
        begin
            want.ctrl.aluSrcA = SrcAReg;
            want.ctrl.aluSrcB = SrcBReg;
            cls = AluFunct;
        end
        AluWB:
        begin
            want.ctrl.resultSrc = ResAluOut;
            want.ctrl.regWrite  = 1'b1;
        end
        Jal:
        begin
            want.ctrl.pcWrite   = 1'b1;
            want.ctrl.aluSrcA   = SrcAOldPc;
            want.ctrl.aluSrcB   = SrcBFour;
            want.ctrl.resultSrc = ResAluOut;
        end
        // Taken branch only when the ALU difference is zero
        Beq:
        begin
            want.ctrl.aluSrcA   = SrcAReg;
            want.ctrl.aluSrcB   = SrcBReg;
            want.ctrl.resultSrc = ResAluOut;
            want.ctrl.pcWrite   = zeroIn;
            cls = AluSub;
        end
        Lui:
        begin
            want.ctrl.aluSrcA = SrcAZero;
            want.ctrl.aluSrcB = SrcBImm;
        end
        default:
        begin
            want.ctrl = '0;
        end
    endcase
    want.aluControl = refAluControl(cls, fields);
    want.immSrc     = refImmSrc(fields.op);
    return want;
endfunction

// Clocks from Fetch back to Fetch
function automatic int expectedCycles(input logic [6:0] op);
    if (op == opLoad)
        return 5;
    if (op == opStore || op == opRType || op == opIType || op == opJal || op == opLui)
        return 4;
    if (op == opBranch)
        return 3;
    if (op == opNop)
        return 2;
    return 0;
endfunction

`endif

// File: sim/controllerTb.sv
// Directed and random test of the multicycle controller against a reference model
// Inputs change 2 ns after each rising edge, outputs are sampled 2 ns before it
// Random stream uses a fixed seed

`timescale 1ns/1ps

module controllerTb;

    import cpuCtrlPkg::*;

    localparam int periodNs      = 40;
    localparam int driveDelayNs  = 2;
    localparam int sampleDelayNs = 38;
    localparam int randomCount   = 300;
    // lw, sw, 16 R-type, 16 I-type, jal, lui, nop, 4 beq, plus the fault case
    localparam int directedCount = 42;
    localparam int totalInstr    = directedCount + randomCount;
    localparam int marginCycles  = 60;
    localparam int timeoutNs     = (totalInstr * 5 + marginCycles) * periodNs;
    localparam int zeroRandom    = 2;
    localparam int maxCycles     = 8;

    logic         clk;
    logic         resetn;
    logic         resetReq;
    instrFields_t instr;
    logic         zero;
    fsmCtrl_t     ctrl;
    aluCtrl_e     aluControl;
    immSrc_e      immSrc;

    // Model state, updated on each rising edge
    ctrlState_e   modelState;
    string        testName;

    `include "ctrlModel.svh"

    clockGen clocks (
        .resetReq (resetReq),
        .clk      (clk),
        .resetn   (resetn)
    );

    multicycleController dut (
        .clk        (clk),
        .resetn     (resetn),
        .instr      (instr),
        .zero       (zero),
        .ctrl       (ctrl),
        .aluControl (aluControl),
        .immSrc     (immSrc)
    );

    task automatic checkCtrl(input string name, input fsmCtrl_t expected, input fsmCtrl_t actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: ctrl expected %b actual %b", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "control level mismatch");
        end
    endtask

    task automatic checkAluControl(input string name, input aluCtrl_e expected,
                                   input aluCtrl_e actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: aluControl expected %s actual %s", name, expected.name(),
                     actual.name());
            $display("Testbench failed");
            $fatal(1, "ALU operation mismatch");
        end
    endtask

    task automatic checkImmSrc(input string name, input immSrc_e expected, input immSrc_e actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: immSrc expected %s actual %s", name, expected.name(),
                     actual.name());
            $display("Testbench failed");
            $fatal(1, "immediate format mismatch");
        end
    endtask

    task automatic checkCycles(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("[ERROR] %s: cycles expected %0d actual %0d", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "cycle count mismatch");
        end
    endtask

    function automatic instrFields_t makeInstr(input logic [6:0] op, input logic [2:0] f3,
                                               input logic b5);
        instrFields_t fields;
        fields.op       = op;
        fields.funct3   = f3;
        fields.funct7b5 = b5;
        return fields;
    endfunction

    // Uniform pick over the supported opcodes
    function automatic logic [6:0] randomOpcode();
        case ($urandom % 8)
            0: return opLoad;
            1: return opStore;
            2: return opRType;
            3: return opIType;
            4: return opJal;
            5: return opBranch;
            6: return opLui;
            default: return opNop;
        endcase
    endfunction

    task automatic driveZero(input int mode);
        if (mode == zeroRandom)
            zero = 1'($urandom % 2);
        else
            zero = 1'(mode);
    endtask

    // Returns 2 ns after an edge that entered Fetch
    task automatic waitForFetch();
        while (modelState != Fetch)
        begin
            @(posedge clk);
            #(driveDelayNs);
        end
    endtask

    // Runs one instruction and counts DUT clocks until it shows Fetch again
    task automatic runInstr(input string name, input instrFields_t fields, input int zeroMode);
        int cycles;
        waitForFetch();
        testName = name;
        instr    = fields;
        cycles   = 0;
        do
        begin
            driveZero(zeroMode);
            cycles++;
            @(posedge clk);
            #(driveDelayNs);
        end
        // Only Fetch raises irWrite
        while (ctrl.irWrite !== 1'b1 && cycles < maxCycles);
        checkCycles(name, expectedCycles(fields.op), cycles);
    endtask

    // Unknown opcode parks in Error, then a reset brings Fetch back
    task automatic runFault();
        int cycles;
        waitForFetch();
        testName = "illegal opcode";
        instr    = makeInstr(7'b1111111, 3'b000, 1'b0);
        for (cycles = 0; cycles < maxCycles; cycles++)
        begin
            driveZero(zeroRandom);
            @(posedge clk);
            #(driveDelayNs);
        end
        testName = "reset from error";
        resetReq = 1'b1;
        instr    = makeInstr(opNop, 3'b000, 1'b0);
        repeat (2)
        begin
            @(posedge clk);
            #(driveDelayNs);
        end
        resetReq = 1'b0;
    endtask

    // Model steps on the edge and outputs are checked late in the cycle
    initial
    begin
        expected_t want;
        modelState = Fetch;
        forever
        begin
            @(posedge clk);
            if (resetn)
                modelState = Fetch;
            else
                modelState = refNextState(modelState, instr);
            #(sampleDelayNs);
            want = refOutputs(modelState, instr, zero);
            checkCtrl($sformatf("%s [%s]", testName, modelState.name()), want.ctrl, ctrl);
            checkAluControl($sformatf("%s [%s]", testName, modelState.name()),
                            want.aluControl, aluControl);
            checkImmSrc($sformatf("%s [%s]", testName, modelState.name()), want.immSrc, immSrc);
        end
    end

    // Stimulus
    initial
    begin
        int i;
        void'($urandom(67));
        instr    = makeInstr(opNop, 3'b000, 1'b0);
        zero     = 1'b0;
        resetReq = 1'b0;
        testName = "reset";
        @(negedge resetn);

        runInstr("lw", makeInstr(opLoad, 3'b010, 1'b0), zeroRandom);
        runInstr("sw", makeInstr(opStore, 3'b010, 1'b0), zeroRandom);
        // Every funct3 with bit 30 clear then set
        for (i = 0; i < 16; i++)
        begin
            runInstr($sformatf("rtype f3=%0d b5=%0d", i % 8, i / 8),
                     makeInstr(opRType, 3'(i % 8), 1'(i / 8)), zeroRandom);
        end
        for (i = 0; i < 16; i++)
        begin
            runInstr($sformatf("itype f3=%0d b5=%0d", i % 8, i / 8),
                     makeInstr(opIType, 3'(i % 8), 1'(i / 8)), zeroRandom);
        end
        runInstr("jal", makeInstr(opJal, 3'b000, 1'b0), zeroRandom);
        runInstr("lui", makeInstr(opLui, 3'b000, 1'b0), zeroRandom);
        runInstr("nop", makeInstr(opNop, 3'b000, 1'b0), zeroRandom);
        runInstr("beq not taken", makeInstr(opBranch, 3'b000, 1'b0), 0);
        runInstr("beq taken", makeInstr(opBranch, 3'b000, 1'b0), 1);
        runInstr("beq random zero b5=1", makeInstr(opBranch, 3'b000, 1'b1), zeroRandom);
        runInstr("beq random zero b5=0", makeInstr(opBranch, 3'b000, 1'b0), zeroRandom);

        runFault();

        for (i = 0; i < randomCount; i++)
        begin
            runInstr($sformatf("random %0d", i),
                     makeInstr(randomOpcode(), 3'($urandom % 8), 1'($urandom % 2)), zeroRandom);
        end

        // Let the last cycle be compared
        #(periodNs);
        $display("Testbench passed");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(timeoutNs);
        $display("Timeout: the test did not finish within %0d ns", timeoutNs);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: sim/clockGen.sv
// Testbench clock and reset, 40 ns period
// resetn is high for the first 3 rising edges and while resetReq is high

`timescale 1ns/1ps

module clockGen (
    input  logic resetReq,
    output logic clk,
    output logic resetn
);

    localparam int halfPeriodNs = 20;
    localparam int resetCycles  = 3;
    localparam int releaseNs    = 2;

    logic powerOnReset;

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(halfPeriodNs) clk = ~clk;
        end
    end

    // Released just after an edge, like the other inputs
    initial
    begin
        powerOnReset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #(releaseNs) powerOnReset = 1'b0;
    end

    assign resetn = powerOnReset | resetReq;

endmodule

// File: hw/multicycleController.sv
// Control unit top: Moore FSM plus combinational ALU/immediate decoder
// All outputs are levels valid during the current state, no handshakes
// resetn is synchronous and active high

`timescale 1ns/1ps

module multicycleController (
    input  logic                     clk,
    input  logic                     resetn,
    input  cpuCtrlPkg::instrFields_t instr,
    input  logic                     zero,
    output cpuCtrlPkg::fsmCtrl_t     ctrl,
    output cpuCtrlPkg::aluCtrl_e     aluControl,
    output cpuCtrlPkg::immSrc_e      immSrc
);

    import cpuCtrlPkg::*;

    // ALU class from FSM to decoder
    aluOp_e aluOp;

    // Sequencing and datapath levels
    mainFsm fsm (
        .clk    (clk),
        .resetn (resetn),
        .instr  (instr),
        .zero   (zero),
        .ctrl   (ctrl),
        .aluOp  (aluOp)
    );

    // Zero-latency decode
    instrDecoder decoder (
        .instr      (instr),
        .aluOp      (aluOp),
        .aluControl (aluControl),
        .immSrc     (immSrc)
    );

endmodule

// File: hw/mainFsm.sv
// Moore FSM of the multicycle controller, one clock per state
// Reset is synchronous and active high and lands in Fetch
// Unknown opcodes park the FSM in Error until the next reset
// pcWrite in Beq is the only output that looks at an input

`timescale 1ns/1ps

module mainFsm (
    input  logic                    clk,
    input  logic                    resetn,
    input  cpuCtrlPkg::instrFields_t instr,
    input  logic                    zero,
    output cpuCtrlPkg::fsmCtrl_t    ctrl,
    output cpuCtrlPkg::aluOp_e      aluOp
);

    import cpuCtrlPkg::*;

    ctrlState_e state;
    ctrlState_e nextState;

    // State register
    always_ff @(posedge clk)
    begin
        if (resetn)
        begin
            state <= Fetch;
        end
        else
        begin
            state <= nextState;
        end
    end

    // Next-state logic
    always_comb
    begin
        nextState = Error;
        case (state)
            Fetch:
            begin
                nextState = Decode;
            end

            // Instruction register is valid from here on
            Decode:
            begin
                case (instr.op)
                    opLoad, opStore:
                    begin
                        nextState = MemAddr;
                    end
                    opRType:
                    begin
                        nextState = ExecuteR;
                    end
                    opIType:
                    begin
                        nextState = ExecuteI;
                    end
                    opJal:
                    begin
                        nextState = Jal;
                    end
                    opBranch:
                    begin
                        nextState = Beq;
                    end
                    opLui:
                    begin
                        nextState = Lui;
                    end
                    // nop, straight back to fetch
                    opNop:
                    begin
                        nextState = Fetch;
                    end
                    default:
                    begin
                        nextState = Error;
                    end
                endcase
            end

            // Split the memory path by direction
            MemAddr:
            begin
                if (instr.op == opLoad)
                begin
                    nextState = MemRead;
                end
                else if (instr.op == opStore)
                begin
                    nextState = MemWrite;
                end
                else
                begin
                    nextState = Error;
                end
            end

            MemRead:
            begin
                nextState = MemWB;
            end

            // Single write-back state for ALU, jal and lui results
            ExecuteR, ExecuteI, Jal, Lui:
            begin
                nextState = AluWB;
            end

            MemWB, MemWrite, AluWB, Beq:
            begin
                nextState = Fetch;
            end

            // Fault holds
            Error:
            begin
                nextState = Error;
            end

            // Unused encodings count as a fault
            default:
            begin
                nextState = Error;
            end
        endcase
    end

    // Per-state control levels
    always_comb
    begin
        // Everything low, ALU adds
        ctrl  = '0;
        aluOp = AluAdd;
        case (state)
            // Read instruction at PC, PC += 4
            Fetch:
            begin
                ctrl.irWrite   = 1'b1;
                ctrl.pcWrite   = 1'b1;
                ctrl.adrSrc    = AdrFromPc;
                ctrl.aluSrcA   = SrcAPc;
                ctrl.aluSrcB   = SrcBFour;
                ctrl.resultSrc = ResAluResult;
            end

            // Branch/jump target oldPC + imm, kept in ALUOut
            Decode:
            begin
                ctrl.aluSrcA = SrcAOldPc;
                ctrl.aluSrcB = SrcBImm;
            end

            // rs1 + offset
            MemAddr:
            begin
                ctrl.aluSrcA = SrcAReg;
                ctrl.aluSrcB = SrcBImm;
            end

            // Address from ALUOut via result bus
            MemRead:
            begin
                ctrl.adrSrc    = AdrFromResult;
                ctrl.resultSrc = ResAluOut;
            end

            MemWB:
            begin
                ctrl.resultSrc = ResData;
                ctrl.regWrite  = 1'b1;
            end

            MemWrite:
            begin
                ctrl.adrSrc    = AdrFromResult;
                ctrl.resultSrc = ResAluOut;
                ctrl.memWrite  = 1'b1;
            end

            // Operation picked by the decoder from funct fields
            ExecuteR:
            begin
                ctrl.aluSrcA = SrcAReg;
                ctrl.aluSrcB = SrcBReg;
                aluOp        = AluFunct;
            end

            ExecuteI:
            begin
                ctrl.aluSrcA = SrcAReg;
                ctrl.aluSrcB = SrcBImm;
                aluOp        = AluFunct;
            end

            AluWB:
            begin
                ctrl.resultSrc = ResAluOut;
                ctrl.regWrite  = 1'b1;
            end

            // PC takes target from ALUOut while ALU forms the link value
            Jal:
            begin
                ctrl.pcWrite   = 1'b1;
                ctrl.aluSrcA   = SrcAOldPc;
                ctrl.aluSrcB   = SrcBFour;
                ctrl.resultSrc = ResAluOut;
            end

            // rs1 - rs2, take the branch on zero
            Beq:
            begin
                ctrl.aluSrcA   = SrcAReg;
                ctrl.aluSrcB   = SrcBReg;
                ctrl.resultSrc = ResAluOut;
                ctrl.pcWrite   = zero;
                aluOp          = AluSub;
            end

            // 0 + upper immediate
            Lui:
            begin
                ctrl.aluSrcA = SrcAZero;
                ctrl.aluSrcB = SrcBImm;
            end

            // Error and unused codes keep all levels low
            default:
            begin
                ctrl  = '0;
                aluOp = AluAdd;
            end
        endcase
    end

endmodule

// File: hw/instrDecoder.sv
// Combinational ALU-operation and immediate-format decode
// Sub needs both opcode bit 5 (register form) and funct7b5
// Unsupported funct3 or opcode values fall back to add and ImmI

`timescale 1ns/1ps

module instrDecoder (
    input  cpuCtrlPkg::instrFields_t instr,
    input  cpuCtrlPkg::aluOp_e       aluOp,
    output cpuCtrlPkg::aluCtrl_e     aluControl,
    output cpuCtrlPkg::immSrc_e      immSrc
);

    import cpuCtrlPkg::*;

    // Register-form subtract, addi never subtracts
    logic rTypeSub;

    assign rTypeSub = instr.op[5] & instr.funct7b5;

    // ALU operation
    always_comb
    begin
        case (aluOp)
            AluAdd:
            begin
                aluControl = CtrlAdd;
            end
            AluSub:
            begin
                aluControl = CtrlSub;
            end
            // R-type and I-type ALU ops
            AluFunct:
            begin
                case (instr.funct3)
                    f3AddSub:
                    begin
                        aluControl = rTypeSub ? CtrlSub : CtrlAdd;
                    end
                    f3Slt:
                    begin
                        aluControl = CtrlSlt;
                    end
                    f3Xor:
                    begin
                        aluControl = CtrlXor;
                    end
                    f3Or:
                    begin
                        aluControl = CtrlOr;
                    end
                    f3And:
                    begin
                        aluControl = CtrlAnd;
                    end
                    // Shifts, sltu and the rest
                    default:
                    begin
                        aluControl = CtrlAdd;
                    end
                endcase
            end
            default:
            begin
                aluControl = CtrlAdd;
            end
        endcase
    end

    // Immediate format by opcode
    always_comb
    begin
        case (instr.op)
            opLoad, opIType:
            begin
                immSrc = ImmI;
            end
            opStore:
            begin
                immSrc = ImmS;
            end
            opBranch:
            begin
                immSrc = ImmB;
            end
            opJal:
            begin
                immSrc = ImmJ;
            end
            opLui:
            begin
                immSrc = ImmU;
            end
            default:
            begin
                immSrc = ImmI;
            end
        endcase
    end

endmodule

// File: hw/cpuCtrlPkg.sv
// Shared types and constants for the multicycle RV32I controller
// Only lw/sw, R-type, I-type ALU, jal, beq, lui and nop (opcode zero) are known
// Select encodings must match the datapath mux input order

package cpuCtrlPkg;

    // Instruction field widths
    localparam int opWidth     = 7;
    localparam int funct3Width = 3;

    // RV32I opcodes of the supported classes
    localparam logic [opWidth-1:0] opLoad   = 7'b0000011;
    localparam logic [opWidth-1:0] opStore  = 7'b0100011;
    localparam logic [opWidth-1:0] opRType  = 7'b0110011;
    localparam logic [opWidth-1:0] opIType  = 7'b0010011;
    localparam logic [opWidth-1:0] opJal    = 7'b1101111;
    localparam logic [opWidth-1:0] opBranch = 7'b1100011;
    localparam logic [opWidth-1:0] opLui    = 7'b0110111;
    // All-zero word treated as nop
    localparam logic [opWidth-1:0] opNop    = 7'b0000000;

    // funct3 codes of the ALU instructions
    localparam logic [funct3Width-1:0] f3AddSub = 3'b000;
    localparam logic [funct3Width-1:0] f3Slt    = 3'b010;
    localparam logic [funct3Width-1:0] f3Xor    = 3'b100;
    localparam logic [funct3Width-1:0] f3Or     = 3'b110;
    localparam logic [funct3Width-1:0] f3And    = 3'b111;

    // Fields of the instruction register seen by the controller
    typedef struct packed {
        logic [opWidth-1:0]     op;
        logic [funct3Width-1:0] funct3;
        // Instruction bit 30, picks sub over add
        logic                   funct7b5;
    } instrFields_t;

    // Controller states, one clock each
    typedef enum logic [3:0] {
        Fetch    = 4'd0,
        Decode   = 4'd1,
        MemAddr  = 4'd2,
        MemRead  = 4'd3,
        MemWB    = 4'd4,
        MemWrite = 4'd5,
        ExecuteR = 4'd6,
        ExecuteI = 4'd7,
        AluWB    = 4'd8,
        Jal      = 4'd9,
        Beq      = 4'd10,
        Lui      = 4'd11,
        // Sticky until reset
        Error    = 4'd12
    } ctrlState_e;

    // ALU class requested by the FSM
    typedef enum logic [1:0] {
        AluAdd   = 2'b00,
        AluSub   = 2'b01,
        AluFunct = 2'b10
    } aluOp_e;

    // ALU operation select
    typedef enum logic [2:0] {
        CtrlAdd = 3'b000,
        CtrlSub = 3'b001,
        CtrlAnd = 3'b010,
        CtrlOr  = 3'b011,
        CtrlXor = 3'b100,
        CtrlSlt = 3'b101
    } aluCtrl_e;

    // Immediate format for the extender
    typedef enum logic [2:0] {
        ImmI = 3'b000,
        ImmS = 3'b001,
        ImmB = 3'b010,
        ImmJ = 3'b011,
        ImmU = 3'b100
    } immSrc_e;

    // Result bus source
    typedef enum logic [1:0] {
        ResAluOut    = 2'b00,
        ResData      = 2'b01,
        ResAluResult = 2'b10
    } resultSrc_e;

    // ALU A operand
    typedef enum logic [1:0] {
        SrcAPc    = 2'b00,
        SrcAOldPc = 2'b01,
        SrcAReg   = 2'b10,
        SrcAZero  = 2'b11
    } srcA_e;

    // ALU B operand
    typedef enum logic [1:0] {
        SrcBReg  = 2'b00,
        SrcBImm  = 2'b01,
        SrcBFour = 2'b10
    } srcB_e;

    // Memory address source
    typedef enum logic {
        AdrFromPc     = 1'b0,
        AdrFromResult = 1'b1
    } adrSrc_e;

    // Datapath control levels from the FSM
    typedef struct packed {
        logic       pcWrite;
        adrSrc_e    adrSrc;
        logic       memWrite;
        logic       irWrite;
        resultSrc_e resultSrc;
        srcA_e      aluSrcA;
        srcB_e      aluSrcB;
        logic       regWrite;
    } fsmCtrl_t;

endpackage
